// File: bench/bus_input.txt
# name op addr data check expected, all but name in hex, one CPU cycle per line
# op 0 idle 1 io_rd 2 io_wr 3 mem_rd 4 mem_wr 5 flag_pulse 6 joy_rd
reset_rom0     3 0123 00 2 000123
reset_rom1     3 4567 00 2 004567
reset_rom2     3 89ab 00 2 0089ab
reset_bios     3 0123 00 1 0000b1
reset_ram      3 c000 00 1 00003a
reset_ram_addr 3 c000 00 2 00c000
map_slot1      4 fffe 05 c 000001
map_rd_slot1   3 4567 00 2 014567
map_slot2      4 ffff 0a 0 000000
map_rd_slot2   3 89ab 00 2 0289ab
map_slot0      4 fffd 03 0 000000
map_rd_slot0   3 0123 00 2 00c123
map_rom_we     4 8000 77 c 000000
mem_ctrl_wr    2 003e 08 0 000000
mem_rom_data   3 0123 00 1 000090
vdp_r1_lo      2 00bf 40 0 000000
vdp_r1_hi      2 00bf 81 a 000001
vdp_r0_lo      2 00bf 04 0 000000
vdp_r0_hi      2 00bf 80 5 000004
vdp_r2_lo      2 00bf 0e 0 000000
vdp_r2_hi      2 00bf 82 6 003800
vdp_r3_lo      2 00bf ff 0 000000
vdp_r3_hi      2 00bf 83 7 003fc0
vdp_r8_lo      2 00bf 12 0 000000
vdp_r8_hi      2 00bf 88 8 000012
vdp_r9_lo      2 00bf 34 0 000000
vdp_r9_hi      2 00bf 89 9 000034
vdp_m2_lo      2 00bf 02 0 000000
vdp_m2_hi      2 00bf 80 5 000002
vdp_m2_color   0 0000 00 7 002000
vram_lo        2 00bf 00 0 000000
vram_hi        2 00bf 41 3 000100
vram_wr0       2 00be 11 3 000101
vram_wr1       2 00be 22 3 000102
vram_wr2       2 00be 33 3 000103
cram_lo        2 00bf 10 0 000000
cram_hi        2 00bf c0 4 000001
cram_addr      0 0000 00 3 000010
vrd_lo         2 00bf 00 0 000000
vrd_hi         2 00bf 02 4 000000
vrd_first      1 00be 00 3 000200
vrd_data       1 00be 00 1 00005c
vrd_end        0 0000 00 3 000201
stat_idle      1 00bf 00 1 00001f
stat_gap0      0 0000 00 0 000000
col_pulse      5 0000 01 0 000000
stat_col       1 00bf 00 1 00003f
stat_gap1      0 0000 00 0 000000
stat_clear     1 00bf 00 1 00001f
stat_gap2      0 0000 00 0 000000
int_col_pulse  5 0000 03 0 000000
stat_both      1 00bf 00 1 0000bf
joy0_a         6 00dc 00 b 000000
joy0_b         6 00dc 00 b 000000
joy0_c         6 00dc 00 b 000000
joy1           1 00dd 00 1 0000bf
vcount         1 007e 00 1 00006a
hcount         1 007f 00 1 000095

// File: list.f
common/sms_bus_pkg.sv
common/sms_vdp_pkg.sv
source/bus_decode.sv
source/mem_mapper.sv
vdp_port/vdp_port_ctrl.sv
vdp_port/vdp_status.sv
source/read_mux.sv
source/sms_bus_top.sv
bench/tb_sms_bus.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the bus controller testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_sms_bus -f list.f -o sim_tb_sms_bus

# The simulator exits non-zero on a failed check, the log decides
./obj_dir/sim_tb_sms_bus > sim.log 2>&1 || true
cat sim.log

if grep -qx "Result: PASSED" sim.log; then
  exit 0
else
  exit 1
fi

// File: bench/tb_sms_bus.sv
`timescale 1ns/1ns

module tb_sms_bus;

  import sms_bus_pkg::*;
  import sms_vdp_pkg::*;

  localparam int c_div_bits     = 3;
  localparam int c_cycle_clocks = 2 ** c_div_bits; // Clocks per CPU cycle
  localparam int c_clk_period   = 10;
  localparam int c_reset_cycles = 16;

  localparam data_t c_bios_byte = 8'hB1;
  localparam data_t c_rom_byte  = 8'h90;
  localparam data_t c_ram_byte  = 8'h3A;
  localparam data_t c_vdp_byte  = 8'h5C;
  localparam data_t c_v_count   = 8'h6A;
  localparam data_t c_h_count   = 8'h95;

  // ====================
  // Stimulus file codes
  // ====================

  localparam logic [3:0] op_idle   = 4'h0;
  localparam logic [3:0] op_io_rd  = 4'h1;
  localparam logic [3:0] op_io_wr  = 4'h2;
  localparam logic [3:0] op_mem_rd = 4'h3;
  localparam logic [3:0] op_mem_wr = 4'h4;
  localparam logic [3:0] op_flags  = 4'h5; // Data bit 0 collision, bit 1 interrupt
  localparam logic [3:0] op_joy_rd = 4'h6; // I/O read with fresh random buttons

  localparam logic [3:0] chk_none     = 4'h0;
  localparam logic [3:0] chk_data_in  = 4'h1;
  localparam logic [3:0] chk_rom_addr = 4'h2;
  localparam logic [3:0] chk_vdp_addr = 4'h3;
  localparam logic [3:0] chk_cram     = 4'h4;
  localparam logic [3:0] chk_mode     = 4'h5;
  localparam logic [3:0] chk_name     = 4'h6;
  localparam logic [3:0] chk_color    = 4'h7;
  localparam logic [3:0] chk_x_scroll = 4'h8;
  localparam logic [3:0] chk_y_scroll = 4'h9;
  localparam logic [3:0] chk_video_on = 4'hA;
  localparam logic [3:0] chk_joy      = 4'hB; // Expected byte from the button draw
  localparam logic [3:0] chk_ram_we   = 4'hC;

  logic       cpuClock;
  logic       n_hard_reset;
  addr_t      cpu_address;
  data_t      cpu_data;
  logic       n_wr;
  logic       n_rd;
  logic       n_mreq;
  logic       n_iorq;
  logic       interrupt_flag;
  logic       sprite_collision;
  logic [6:0] joy_n;
  logic       cpu_clock_enable;
  data_t      cpu_data_in;
  rom_addr_t  rom_address;
  logic       ram_we;
  vdp_addr_t  vdp_addr;
  logic       vdp_wr;
  logic       vdp_rd;
  logic       cram_selected;
  vdp_mode_t  mode;
  vdp_addr_t  name_table_addr;
  vdp_addr_t  color_table_addr;
  data_t      x_scroll;
  data_t      y_scroll;
  logic       video_on;

  string       name_q [$];
  logic [3:0]  op_q [$];
  addr_t       addr_q [$];
  data_t       data_q [$];
  logic [3:0]  chk_q [$];
  logic [23:0] exp_q [$];
  int          line_count;
  logic        loaded;
  logic        failed;
  logic [31:0] lfsr_state;
  int          wr_pulses = 0;
  int          rd_pulses = 0;
  int          wr_start;
  int          rd_start;
  time         last_fall;

  sms_bus_top #(
    .p_clock_div_bits (c_div_bits)
  ) dut0 (
    .cpuClock           (cpuClock),
    .n_hard_reset       (n_hard_reset),
    .i_cpu_address      (cpu_address),
    .i_cpu_data         (cpu_data),
    .i_n_wr             (n_wr),
    .i_n_rd             (n_rd),
    .i_n_mreq           (n_mreq),
    .i_n_iorq           (n_iorq),
    .i_interrupt_flag   (interrupt_flag),
    .i_sprite_collision (sprite_collision),
    .i_too_many_sprites (1'b0),
    .i_spritex          (5'h00),
    .i_vdp_data         (c_vdp_byte),
    .i_v_counter        (c_v_count),
    .i_h_counter        (c_h_count),
    .i_joy_n            (joy_n),
    .i_bios_data        (c_bios_byte),
    .i_rom_data         (c_rom_byte),
    .i_ram_data         (c_ram_byte),
    .o_cpu_clock_enable (cpu_clock_enable),
    .o_cpu_data_in      (cpu_data_in),
    .o_rom_address      (rom_address),
    .o_ram_we           (ram_we),
    .o_vdp_addr         (vdp_addr),
    .o_vdp_wr           (vdp_wr),
    .o_vdp_rd           (vdp_rd),
    .o_cram_selected    (cram_selected),
    .o_mode             (mode),
    .o_name_table_addr  (name_table_addr),
    .o_color_table_addr (color_table_addr),
    .o_x_scroll         (x_scroll),
    .o_y_scroll         (y_scroll),
    .o_video_on         (video_on)
  );

  always #(c_clk_period / 2) cpuClock = ~cpuClock;

  // Running count of VDP strobes
  always @(posedge cpuClock) begin
    if (vdp_wr) wr_pulses <= wr_pulses + 1;
    if (vdp_rd) rd_pulses <= rd_pulses + 1;
  end

  // ====================
  // Helpers
  // ====================

  task automatic abort_run(input string reason);
    $display("%s", reason);
    failed = 1'b1;
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  // Galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
      lfsr_step = (state >> 1) ^ 32'h8020_0003;
    end else begin
      lfsr_step = state >> 1;
    end
  endfunction

  task automatic draw_buttons(output logic [6:0] buttons);
    for (int i = 0; i < 7; i++) begin
      buttons[i] = lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  // Pressed buttons read as ones below two fixed ones
  function automatic data_t joy_port_byte(input logic [6:0] joy);
    data_t port_byte;
    port_byte = 8'hC0;
    for (int d = 0; d < 4; d++) begin
      if (!joy[3 + d]) port_byte[d] = 1'b1; // Directions
    end
    for (int f = 0; f < 2; f++) begin
      if (!joy[1 + f]) port_byte[4 + f] = 1'b1; // Fire buttons
    end
    return port_byte;
  endfunction

  function automatic logic [23:0] observed(input logic [3:0] chk);
    case (chk)
      chk_data_in:  observed = 24'(cpu_data_in);
      chk_joy:      observed = 24'(cpu_data_in);
      chk_rom_addr: observed = rom_address;
      chk_vdp_addr: observed = 24'(vdp_addr);
      chk_cram:     observed = 24'(cram_selected);
      chk_mode:     observed = 24'(mode);
      chk_name:     observed = 24'(name_table_addr);
      chk_color:    observed = 24'(color_table_addr);
      chk_x_scroll: observed = 24'(x_scroll);
      chk_y_scroll: observed = 24'(y_scroll);
      chk_video_on: observed = 24'(video_on);
      chk_ram_we:   observed = 24'(ram_we);
      default:      observed = '0;
    endcase
  endfunction

  task automatic load_stimulus();
    int              fd;
    int              fields;
    string           line;
    logic [8*24-1:0] name_buf;
    logic [3:0]      op;
    addr_t           addr;
    data_t           data;
    logic [3:0]      chk;
    logic [23:0]     expected;
    fd = $fopen("bench/bus_input.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open the stimulus file bench/bus_input.txt");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.getc(0) != "#") begin
        fields = $sscanf(line, "%s %h %h %h %h %h", name_buf, op, addr, data, chk, expected);
        if (fields == 6) begin
          name_q.push_back(string'(name_buf));
          op_q.push_back(op);
          addr_q.push_back(addr);
          data_q.push_back(data);
          chk_q.push_back(chk);
          exp_q.push_back(expected);
        end else if (fields > 0) begin
          abort_run({"Malformed stimulus line: ", line});
        end
      end
    end
    $fclose(fd);
    line_count = op_q.size();
  endtask

  task automatic drive_line(input logic [3:0] op, input addr_t addr, input data_t data);
    cpu_address = addr;
    cpu_data    = data;
    n_wr        = 1'b1;
    n_rd        = 1'b1;
    n_mreq      = 1'b1;
    n_iorq      = 1'b1;
    case (op)
      op_io_rd, op_joy_rd: begin
        n_iorq = 1'b0;
        n_rd   = 1'b0;
      end
      op_io_wr: begin
        n_iorq = 1'b0;
        n_wr   = 1'b0;
      end
      op_mem_rd: begin
        n_mreq = 1'b0;
        n_rd   = 1'b0;
      end
      op_mem_wr: begin
        n_mreq = 1'b0;
        n_wr   = 1'b0;
      end
      default: begin
      end
    endcase
    if (op == op_joy_rd) draw_buttons(joy_n);
    if (op == op_flags) begin
      sprite_collision = data[0]; // Dropped again one clock later
      interrupt_flag   = data[1];
    end
  endtask

  task automatic check_enable(input string name, input logic want);
    assert (cpu_clock_enable == want) else
      abort_run($sformatf("[ERROR] %0s: cpu_clock_enable expected %0b, actual %0b",
                          name, want, cpu_clock_enable));
  endtask

  task automatic check_line(input int n);
    logic        data_port;
    int          wr_want;
    int          rd_want;
    logic [23:0] want;
    logic [23:0] got;
    data_port = (addr_q[n][7:6] == 2'b10) && !addr_q[n][0];
    wr_want   = (op_q[n] == op_io_wr && data_port) ? 1 : 0;
    rd_want   = ((op_q[n] == op_io_rd || op_q[n] == op_joy_rd) && data_port) ? 1 : 0;
    assert (wr_pulses - wr_start == wr_want) else
      abort_run($sformatf("[ERROR] %0s: vdp_wr pulses expected %0d, actual %0d",
                          name_q[n], wr_want, wr_pulses - wr_start));
    assert (rd_pulses - rd_start == rd_want) else
      abort_run($sformatf("[ERROR] %0s: vdp_rd pulses expected %0d, actual %0d",
                          name_q[n], rd_want, rd_pulses - rd_start));
    if (chk_q[n] != chk_none) begin
      want = (chk_q[n] == chk_joy) ? 24'(joy_port_byte(joy_n)) : exp_q[n];
      got  = observed(chk_q[n]);
      assert (got == want) else
        abort_run($sformatf("[ERROR] %0s: expected %0h, actual %0h", name_q[n], want, got));
    end
  endtask

  // ====================
  // Main sequence
  // ====================

  initial begin
    cpuClock         = 1'b0;
    n_hard_reset     = 1'b0;
    cpu_address      = '0;
    cpu_data         = '0;
    n_wr             = 1'b1;
    n_rd             = 1'b1;
    n_mreq           = 1'b1;
    n_iorq           = 1'b1;
    interrupt_flag   = 1'b0;
    sprite_collision = 1'b0;
    joy_n            = 7'h7F; // Nothing pressed
    lfsr_state       = 32'h71dc_eef8;
    failed           = 1'b0;
    loaded           = 1'b0;
    line_count       = 0;
    last_fall        = 0;
    load_stimulus();
    loaded = 1'b1;
    repeat (c_reset_cycles) @(negedge cpuClock);
    n_hard_reset = 1'b1;

    // One file line per CPU cycle, checked on its last clock
    for (int n = 0; n < line_count; n++) begin
      @(negedge cpu_clock_enable);
      if (n > 0) begin
        assert ($time - last_fall == c_cycle_clocks * c_clk_period) else
          abort_run($sformatf("[ERROR] %0s: enable period expected %0d ns, actual %0d ns",
                              name_q[n], c_cycle_clocks * c_clk_period,
                              $time - last_fall));
      end
      last_fall = $time;
      @(negedge cpuClock);
      wr_start = wr_pulses;
      rd_start = rd_pulses;
      drive_line(op_q[n], addr_q[n], data_q[n]);
      @(negedge cpuClock);
      sprite_collision = 1'b0;
      interrupt_flag   = 1'b0;
      repeat (c_cycle_clocks / 2 - 2) @(negedge cpuClock);
      check_enable(name_q[n], 1'b0); // Last low clock
      @(negedge cpuClock);
      check_enable(name_q[n], 1'b1); // First high clock
      repeat (c_cycle_clocks / 2 - 1) @(negedge cpuClock);
      check_line(n);
    end

    if (!failed) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      abort_run("One or more checks did not match");
    end
  end

  initial begin : watchdog
    int timeout_ns;
    wait (loaded);
    timeout_ns = line_count * c_cycle_clocks * c_clk_period + 2000;
    #(timeout_ns);
    abort_run($sformatf("Watchdog timeout after %0d ns, the run did not finish", timeout_ns));
  end

endmodule

// File: source/sms_bus_top.sv
`timescale 1ns/1ns

module sms_bus_top #(
  parameter int p_clock_div_bits = 3
) (
  input  logic                   cpuClock,
  input  logic                   n_hard_reset,
  input  sms_bus_pkg::addr_t     i_cpu_address,
  input  sms_bus_pkg::data_t     i_cpu_data,
  input  logic                   i_n_wr,
  input  logic                   i_n_rd,
  input  logic                   i_n_mreq,
  input  logic                   i_n_iorq,
  input  logic                   i_interrupt_flag,
  input  logic                   i_sprite_collision,
  input  logic                   i_too_many_sprites,
  input  logic [4:0]             i_spritex,
  input  sms_bus_pkg::data_t     i_vdp_data,
  input  sms_bus_pkg::data_t     i_v_counter,
  input  sms_bus_pkg::data_t     i_h_counter,
  input  logic [6:0]             i_joy_n,
  input  sms_bus_pkg::data_t     i_bios_data,
  input  sms_bus_pkg::data_t     i_rom_data,
  input  sms_bus_pkg::data_t     i_ram_data,
  output logic                   o_cpu_clock_enable,
  output sms_bus_pkg::data_t     o_cpu_data_in,
  output sms_bus_pkg::rom_addr_t o_rom_address,
  output logic                   o_ram_we,
  output sms_vdp_pkg::vdp_addr_t o_vdp_addr,
  output logic                   o_vdp_wr,
  output logic                   o_vdp_rd,
  output logic                   o_cram_selected,
  output sms_vdp_pkg::vdp_mode_t o_mode,
  output sms_vdp_pkg::vdp_addr_t o_name_table_addr,
  output sms_vdp_pkg::vdp_addr_t o_color_table_addr,
  output sms_bus_pkg::data_t     o_x_scroll,
  output sms_bus_pkg::data_t     o_y_scroll,
  output logic                   o_video_on
);

  import sms_bus_pkg::*;

  logic     cpu_edge;
  io_port_t io_rd_sel;
  io_port_t io_wr_sel;
  logic     io_rd;
  logic     io_wr;
  logic     mem_rd;
  logic     mem_wr;
  data_t    mem_ctrl;
  data_t    status;

  // ====================
  // Decode
  // ====================

  bus_decode #(
    .p_clock_div_bits (p_clock_div_bits)
  ) u_bus_decode (
    .cpuClock           (cpuClock),
    .n_hard_reset       (n_hard_reset),
    .i_cpu_address      (i_cpu_address),
    .i_n_wr             (i_n_wr),
    .i_n_rd             (i_n_rd),
    .i_n_mreq           (i_n_mreq),
    .i_n_iorq           (i_n_iorq),
    .o_cpu_clock_enable (o_cpu_clock_enable),
    .o_cpu_edge         (cpu_edge),
    .o_io_rd_sel        (io_rd_sel),
    .o_io_rd            (io_rd),
    .o_io_wr_sel        (io_wr_sel),
    .o_io_wr            (io_wr),
    .o_mem_rd           (mem_rd),
    .o_mem_wr           (mem_wr)
  );

  // ====================
  // Register state
  // ====================

  mem_mapper u_mem_mapper (
    .cpuClock      (cpuClock),
    .n_hard_reset  (n_hard_reset),
    .i_cpu_edge    (cpu_edge),
    .i_cpu_address (i_cpu_address),
    .i_cpu_data    (i_cpu_data),
    .i_mem_wr      (mem_wr),
    .i_mem_ctrl_wr (io_wr && (io_wr_sel == port_mem_ctrl)),
    .o_mem_ctrl    (mem_ctrl),
    .o_rom_address (o_rom_address),
    .o_ram_we      (o_ram_we)
  );

  vdp_port_ctrl u_vdp_port_ctrl (
    .cpuClock           (cpuClock),
    .n_hard_reset       (n_hard_reset),
    .i_cpu_edge         (cpu_edge),
    .i_cpu_data         (i_cpu_data),
    .i_data_wr          (io_wr && (io_wr_sel == port_vdp_data)),
    .i_data_rd          (io_rd && (io_rd_sel == port_vdp_data)),
    .i_ctrl_wr          (io_wr && (io_wr_sel == port_vdp_ctrl)),
    .i_ctrl_rd          (io_rd && (io_rd_sel == port_vdp_ctrl)),
    .o_vdp_addr         (o_vdp_addr),
    .o_vdp_wr           (o_vdp_wr),
    .o_vdp_rd           (o_vdp_rd),
    .o_cram_selected    (o_cram_selected),
    .o_mode             (o_mode),
    .o_name_table_addr  (o_name_table_addr),
    .o_color_table_addr (o_color_table_addr),
    .o_x_scroll         (o_x_scroll),
    .o_y_scroll         (o_y_scroll),
    .o_video_on         (o_video_on)
  );

  vdp_status u_vdp_status (
    .cpuClock           (cpuClock),
    .n_hard_reset       (n_hard_reset),
    .i_cpu_edge         (cpu_edge),
    .i_ctrl_rd          (io_rd && (io_rd_sel == port_vdp_ctrl)),
    .i_interrupt_flag   (i_interrupt_flag),
    .i_sprite_collision (i_sprite_collision),
    .i_too_many_sprites (i_too_many_sprites),
    .i_spritex          (i_spritex),
    .o_status           (status)
  );

  // ====================
  // Read data
  // ====================

  read_mux u_read_mux (
    .cpuClock      (cpuClock),
    .i_io_rd       (io_rd),
    .i_io_rd_sel   (io_rd_sel),
    .i_mem_rd      (mem_rd),
    .i_cpu_address (i_cpu_address),
    .i_mem_ctrl    (mem_ctrl),
    .i_status      (status),
    .i_vdp_data    (i_vdp_data),
    .i_v_counter   (i_v_counter),
    .i_h_counter   (i_h_counter),
    .i_joy_n       (i_joy_n),
    .i_bios_data   (i_bios_data),
    .i_rom_data    (i_rom_data),
    .i_ram_data    (i_ram_data),
    .o_cpu_data_in (o_cpu_data_in)
  );

endmodule

// File: source/read_mux.sv
`timescale 1ns/1ns

module read_mux (
  input  logic                  cpuClock,
  input  logic                  i_io_rd,
  input  sms_bus_pkg::io_port_t i_io_rd_sel,
  input  logic                  i_mem_rd,
  input  sms_bus_pkg::addr_t    i_cpu_address,
  input  sms_bus_pkg::data_t    i_mem_ctrl,
  input  sms_bus_pkg::data_t    i_status,
  input  sms_bus_pkg::data_t    i_vdp_data,
  input  sms_bus_pkg::data_t    i_v_counter,
  input  sms_bus_pkg::data_t    i_h_counter,
  input  logic [6:0]            i_joy_n,
  input  sms_bus_pkg::data_t    i_bios_data,
  input  sms_bus_pkg::data_t    i_rom_data,
  input  sms_bus_pkg::data_t    i_ram_data,
  output sms_bus_pkg::data_t    o_cpu_data_in
);

  import sms_bus_pkg::*;

  logic [6:0] joy_q; // {right, left, down, up, fire2, fire1, unused}
  data_t      joy_data0;
  data_t      mem_data;

  always_ff @(posedge cpuClock) begin
    joy_q <= i_joy_n;
  end

  assign joy_data0 = {2'b11, ~joy_q[2:1], ~joy_q[6:3]};

  // BIOS is paged out by memory control bit 3
  assign mem_data = (i_mem_rd && (i_cpu_address[15:14] < ram_region)) ?
                    (i_mem_ctrl[3] ? i_rom_data : i_bios_data) : i_ram_data;

  always_comb begin
    o_cpu_data_in = mem_data;
    if (i_io_rd) begin
      case (i_io_rd_sel)
        port_vdp_data:  o_cpu_data_in = i_vdp_data;
        port_vdp_ctrl:  o_cpu_data_in = i_status;
        port_joy_0:     o_cpu_data_in = joy_data0;
        port_joy_1:     o_cpu_data_in = 8'hBF;   // No second pad
        port_v_counter: o_cpu_data_in = i_v_counter;
        port_h_counter: o_cpu_data_in = i_h_counter;
        default:        o_cpu_data_in = mem_data;
      endcase
    end
  end

endmodule

// File: vdp_port/vdp_status.sv
`timescale 1ns/1ns

module vdp_status (
  input  logic               cpuClock,
  input  logic               n_hard_reset,
  input  logic               i_cpu_edge,
  input  logic               i_ctrl_rd,
  input  logic               i_interrupt_flag,
  input  logic               i_sprite_collision,
  input  logic               i_too_many_sprites,
  input  logic [4:0]         i_spritex,
  output sms_bus_pkg::data_t o_status
);

  logic int_flag;      // Sticky frame interrupt
  logic collision;     // Sticky sprite collision
  logic status_rd_q;

  // ====================
  // Sticky flags
  // ====================

  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      int_flag    <= 1'b0;
      collision   <= 1'b0;
      status_rd_q <= 1'b0;
    end else begin
      if (i_interrupt_flag) int_flag <= 1'b1;
      if (i_sprite_collision) collision <= 1'b1;
      if (i_cpu_edge) begin
        status_rd_q <= i_ctrl_rd;
        // Clear on the CPU cycle after the status read
        if (status_rd_q && !i_ctrl_rd) begin
          int_flag  <= 1'b0;
          collision <= 1'b0;
        end
      end
    end
  end

  assign o_status = {int_flag, i_too_many_sprites, collision,
                     (i_too_many_sprites ? i_spritex : 5'b11111)};

endmodule

// File: vdp_port/vdp_port_ctrl.sv
`timescale 1ns/1ns

module vdp_port_ctrl (
  input  logic                   cpuClock,
  input  logic                   n_hard_reset,
  input  logic                   i_cpu_edge,
  input  sms_bus_pkg::data_t     i_cpu_data,
  input  logic                   i_data_wr,
  input  logic                   i_data_rd,
  input  logic                   i_ctrl_wr,
  input  logic                   i_ctrl_rd,
  output sms_vdp_pkg::vdp_addr_t o_vdp_addr,
  output logic                   o_vdp_wr,
  output logic                   o_vdp_rd,
  output logic                   o_cram_selected,
  output sms_vdp_pkg::vdp_mode_t o_mode,
  output sms_vdp_pkg::vdp_addr_t o_name_table_addr,
  output sms_vdp_pkg::vdp_addr_t o_color_table_addr,
  output sms_bus_pkg::data_t     o_x_scroll,
  output sms_bus_pkg::data_t     o_y_scroll,
  output logic                   o_video_on
);

  import sms_bus_pkg::*;
  import sms_vdp_pkg::*;

  data_t     vdp_regs [0:vdp_reg_count-1];
  data_t     first_byte;
  vdp_addr_t vdp_addr;
  logic      cram_sel;
  logic      second_byte; // Next control write completes a command
  logic      data_rd_q;
  vdp_cmd_t  cmd;
  logic [3:0] reg_index;
  logic      reg_cmd;

  assign cmd       = vdp_cmd_t'(i_cpu_data[7:6]);
  assign reg_index = i_cpu_data[3:0];
  assign reg_cmd   = i_cpu_edge && i_ctrl_wr && second_byte && (cmd == cmd_reg_write);

  // ====================
  // Control protocol
  // ====================

  always_ff @(posedge cpuClock) begin
    if (i_cpu_edge && i_ctrl_wr && !second_byte) begin
      first_byte <= i_cpu_data; // Low address byte or register value
    end
  end

  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      vdp_addr    <= '0;
      cram_sel    <= 1'b0;
      second_byte <= 1'b0;
      data_rd_q   <= 1'b0;
      for (int i = 0; i < vdp_reg_count; i++) begin
        vdp_regs[i] <= '0;
      end
    end else if (i_cpu_edge) begin
      if (i_data_wr) begin
        vdp_addr <= vdp_addr + 1'b1;
      end
      // Read data is fetched at the old address, so step once the read ends
      data_rd_q <= i_data_rd;
      if (data_rd_q && !i_data_rd) begin
        vdp_addr <= vdp_addr + 1'b1;
      end

      if (i_ctrl_rd || i_data_rd || i_data_wr) begin
        second_byte <= 1'b0;
      end

      if (i_ctrl_wr) begin
        second_byte <= !second_byte;
        if (second_byte) begin
          case (cmd)
            cmd_vram_read, cmd_vram_write: begin
              vdp_addr <= {i_cpu_data[5:0], first_byte};
              cram_sel <= 1'b0;
            end
            cmd_reg_write: begin
              if (reg_index < vdp_reg_count) begin
                vdp_regs[reg_index] <= first_byte;
              end else begin
                vdp_addr <= {8'h00, first_byte[5:0]}; // Treated like CRAM
                cram_sel <= 1'b1;
              end
            end
            default: begin
              vdp_addr <= {8'h00, first_byte[5:0]};
              cram_sel <= 1'b1;
            end
          endcase
        end
      end
    end
  end

  assign o_vdp_addr      = vdp_addr;
  assign o_cram_selected = cram_sel;
  assign o_vdp_wr        = i_cpu_edge && i_data_wr;
  assign o_vdp_rd        = i_cpu_edge && i_data_rd;

  // ====================
  // Mode and table bases
  // ====================

  always_comb begin
    if (vdp_regs[0][2]) begin
      o_mode = mode_4;
    end else if (vdp_regs[1][3]) begin
      o_mode = mode_3;
    end else if (vdp_regs[0][1]) begin
      o_mode = mode_2;
    end else if (vdp_regs[1][4]) begin
      o_mode = mode_1;
    end else begin
      o_mode = mode_0;
    end
  end

  assign o_name_table_addr  = {vdp_regs[2][3:1], 11'b0};
  assign o_color_table_addr = (o_mode == mode_2) ? {vdp_regs[3][7], 13'b0}
                                                 : {vdp_regs[3], 6'b0};
  assign o_x_scroll = vdp_regs[8];
  assign o_y_scroll = vdp_regs[9];
  assign o_video_on = vdp_regs[1][6];

  // Software only writes implemented registers
  a_reg_index : assert property (@(posedge cpuClock) disable iff (!n_hard_reset)
    reg_cmd |-> (reg_index < vdp_reg_count));

endmodule

// File: source/mem_mapper.sv
`timescale 1ns/1ns

module mem_mapper (
  input  logic                   cpuClock,
  input  logic                   n_hard_reset,
  input  logic                   i_cpu_edge,
  input  sms_bus_pkg::addr_t     i_cpu_address,
  input  sms_bus_pkg::data_t     i_cpu_data,
  input  logic                   i_mem_wr,
  input  logic                   i_mem_ctrl_wr,
  output sms_bus_pkg::data_t     o_mem_ctrl,
  output sms_bus_pkg::rom_addr_t o_rom_address,
  output logic                   o_ram_we
);

  import sms_bus_pkg::*;

  data_t      mem_ctrl;
  data_t      mapper_regs [0:3]; // mem_misc, slot0, slot1, slot2
  logic [1:0] region;
  logic       mapper_hit;

  assign region     = i_cpu_address[15:14];
  assign mapper_hit = (i_cpu_address[15:2] == mapper_base[15:2]);

  // ====================
  // Mapper registers
  // ====================

  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      mem_ctrl       <= mem_ctrl_reset;
      mapper_regs[0] <= 8'h00;
      mapper_regs[1] <= 8'h00; // Slots start on the first three banks
      mapper_regs[2] <= 8'h01;
      mapper_regs[3] <= 8'h02;
    end else if (i_cpu_edge) begin
      if (i_mem_ctrl_wr) begin
        mem_ctrl <= i_cpu_data;
      end
      // RAM copy is written as well, see o_ram_we
      if (i_mem_wr && mapper_hit) begin
        mapper_regs[i_cpu_address[1:0]] <= i_cpu_data;
      end
    end
  end

  assign o_mem_ctrl = mem_ctrl;

  // ====================
  // Address formation
  // ====================

  always_comb begin
    if (region == ram_region) begin
      o_rom_address = {8'h00, i_cpu_address}; // Pass through
    end else begin
      o_rom_address = {2'b00, mapper_regs[region + 2'd1], i_cpu_address[13:0]};
    end
  end

  assign o_ram_we = (region == ram_region) && i_mem_wr;

  // Slots and memory control only move on a CPU edge
  a_regs_on_edge : assert property (@(posedge cpuClock) disable iff (!n_hard_reset)
    !i_cpu_edge |=> $stable(mem_ctrl) && $stable(mapper_regs[1])
                    && $stable(mapper_regs[2]) && $stable(mapper_regs[3]));

endmodule

// File: source/bus_decode.sv
`timescale 1ns/1ns

module bus_decode #(
  parameter int p_clock_div_bits = 3
) (
  input  logic                  cpuClock,
  input  logic                  n_hard_reset,
  input  sms_bus_pkg::addr_t    i_cpu_address,
  input  logic                  i_n_wr,
  input  logic                  i_n_rd,
  input  logic                  i_n_mreq,
  input  logic                  i_n_iorq,
  output logic                  o_cpu_clock_enable,
  output logic                  o_cpu_edge,
  output sms_bus_pkg::io_port_t o_io_rd_sel,
  output logic                  o_io_rd,
  output sms_bus_pkg::io_port_t o_io_wr_sel,
  output logic                  o_io_wr,
  output logic                  o_mem_rd,
  output logic                  o_mem_wr
);

  import sms_bus_pkg::*;

  localparam logic [p_clock_div_bits-1:0] c_edge_count =
    {1'b1, {(p_clock_div_bits - 1){1'b0}}};

  logic [p_clock_div_bits-1:0] clk_count;
  logic                        io_rd_lvl;
  logic                        io_wr_lvl;
  io_port_t                    port_sel;

  // ====================
  // CPU clock enable
  // ====================

  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      clk_count <= '0;
    end else begin
      clk_count <= clk_count + 1'b1;
    end
  end

  assign o_cpu_clock_enable = clk_count[p_clock_div_bits-1];
  assign o_cpu_edge         = (clk_count == c_edge_count); // First high cycle

  // ====================
  // Strobe decode
  // ====================

  // Z80 strobes are active low
  assign io_rd_lvl = !i_n_rd && !i_n_iorq;
  assign io_wr_lvl = !i_n_wr && !i_n_iorq;
  assign o_mem_rd  = !i_n_rd && !i_n_mreq;
  assign o_mem_wr  = !i_n_wr && !i_n_mreq;

  assign port_sel = io_port_t'({i_cpu_address[7:6], i_cpu_address[0]});

  assign o_io_rd_sel = port_sel;
  assign o_io_rd     = io_rd_lvl;
  assign o_io_wr_sel = port_sel;
  assign o_io_wr     = io_wr_lvl && o_cpu_edge; // One pulse per CPU cycle

  a_io_mem_exclusive : assert property (@(posedge cpuClock) disable iff (!n_hard_reset)
    (io_rd_lvl || io_wr_lvl) |-> !(o_mem_rd || o_mem_wr));

endmodule

// File: common/sms_vdp_pkg.sv
package sms_vdp_pkg;

  // ====================
  // VDP CPU port
  // ====================

  // Registers 0 to 10 are implemented
  localparam int vdp_reg_count = 11;

  typedef logic [13:0] vdp_addr_t; // 16 KB VRAM

  // Top two bits of the second control byte
  typedef enum logic [1:0] {
    cmd_vram_read  = 2'b00,
    cmd_vram_write = 2'b01,
    cmd_reg_write  = 2'b10,
    cmd_cram_write = 2'b11
  } vdp_cmd_t;

  // ====================
  // Display modes
  // ====================

  // Mode 4 is the native Master System mode
  typedef enum logic [2:0] {
    mode_0 = 3'd0,
    mode_1 = 3'd1,
    mode_2 = 3'd2,
    mode_3 = 3'd3,
    mode_4 = 3'd4
  } vdp_mode_t;

endpackage

// File: common/sms_bus_pkg.sv
package sms_bus_pkg;

  // ====================
  // CPU bus types
  // ====================

  typedef logic [15:0] addr_t;     // Z80 address
  typedef logic [7:0]  data_t;     // Z80 data byte
  typedef logic [23:0] rom_addr_t; // Mapped SDRAM byte address

  // ====================
  // I/O port decode
  // ====================

  // Selected by {address[7:6], address[0]}
  typedef enum logic [2:0] {
    port_mem_ctrl  = 3'b000,
    port_joy_ctrl  = 3'b001,
    port_v_counter = 3'b010,
    port_h_counter = 3'b011, // Odd address of the counter group
    port_vdp_data  = 3'b100,
    port_vdp_ctrl  = 3'b101,
    port_joy_0     = 3'b110,
    port_joy_1     = 3'b111
  } io_port_t;

  // ====================
  // Memory map
  // ====================

  // First of four mapper registers: mem_misc, slot0, slot1, slot2
  localparam addr_t mapper_base = 16'hFFFC;

  // Top two address bits of the work RAM region
  localparam logic [1:0] ram_region = 2'd3;

  // Memory control value after reset
  localparam data_t mem_ctrl_reset = 8'hF7;

endpackage
